/* logic/rv_core_pkg.sv */
package rv_core_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	// rv32i major opcodes handled by this core
	localparam logic [6:0] OPCODE_OP     = 7'b0110011;
	localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
	localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
	localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
	localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_e;

	// encodings follow funct3 of the branch instructions
	typedef enum logic [2:0] {
		BR_EQ  = 3'b000,
		BR_NE  = 3'b001,
		BR_LT  = 3'b100,
		BR_GE  = 3'b101,
		BR_LTU = 3'b110,
		BR_GEU = 3'b111
	} branch_op_e;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [31:0]     inst;
		logic            is_ctrl;
	} fetch_pkt_t;

	typedef struct packed {
		logic [XLEN-1:0]       pc;
		logic [XLEN-1:0]       operand_a;
		logic [XLEN-1:0]       operand_b;
		logic [XLEN-1:0]       rs2_val;
		logic [XLEN-1:0]       imm;
		alu_op_e               alu_op;
		branch_op_e            branch_op;
		logic                  is_branch;
		logic                  is_jal;
		logic                  is_jalr;
		logic [REG_ADDR_W-1:0] rd;
		logic                  rd_wen;
	} decode_pkt_t;

	typedef struct packed {
		logic [XLEN-1:0]       pc;
		logic [XLEN-1:0]       result;
		logic [REG_ADDR_W-1:0] rd;
		logic                  rd_wen;
		logic                  is_ctrl;
		logic                  taken;
		logic [XLEN-1:0]       jump_target;
	} exec_pkt_t;

	typedef struct packed {
		logic                  wen;
		logic [REG_ADDR_W-1:0] addr;
		logic [XLEN-1:0]       data;
	} reg_write_t;

	typedef struct packed {
		logic [XLEN-1:0]       pc;
		logic [REG_ADDR_W-1:0] rd;
		logic                  rd_wen;
		logic [XLEN-1:0]       data;
	} commit_t;

endpackage

/* logic/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import rv_core_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = 32'h0000_0000
) (
	input  logic            clock,
	input  logic            reset,
	output logic            fetch_req_o,
	output logic [XLEN-1:0] fetch_addr_o,
	input  logic            fetch_valid_i,
	input  logic [31:0]     fetch_inst_i,
	input  logic            redirect_valid_i,
	input  logic [XLEN-1:0] redirect_pc_i,
	output logic            fetch_valid_o,
	output fetch_pkt_t      fetch_pkt_o
);

	logic [XLEN-1:0] pc_q;
	logic            req_q;
	logic            wait_q;
	logic [6:0]      opcode;
	logic            is_ctrl;

	// pre-decode, only the opcode is needed to spot a jump or branch
	assign opcode = fetch_inst_i[6:0];
	assign is_ctrl = (opcode == OPCODE_JAL) ||
		(opcode == OPCODE_JALR) ||
		(opcode == OPCODE_BRANCH);

	assign fetch_req_o = req_q;
	assign fetch_addr_o = pc_q;

	// pc and request strobe
	always_ff @(posedge clock) begin
		if (reset) begin
			pc_q <= RESET_PC;
			req_q <= 1'b1;
			wait_q <= 1'b0;
		end else if (fetch_valid_i) begin
			if (is_ctrl) begin
				// hold until writeback knows the next pc
				req_q <= 1'b0;
				wait_q <= 1'b1;
			end else begin
				pc_q <= pc_q + XLEN'(4);
				req_q <= 1'b1;
				wait_q <= 1'b0;
			end
		end else if (wait_q && redirect_valid_i) begin
			pc_q <= redirect_pc_i;
			req_q <= 1'b1;
			wait_q <= 1'b0;
		end else begin
			req_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			fetch_valid_o <= 1'b0;
		end else begin
			fetch_valid_o <= fetch_valid_i;
		end
	end

	// pc_q still holds the address of the answered request here
	always_ff @(posedge clock) begin
		if (fetch_valid_i) begin
			fetch_pkt_o.pc <= pc_q;
			fetch_pkt_o.inst <= fetch_inst_i;
			fetch_pkt_o.is_ctrl <= is_ctrl;
		end
	end

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps

module register_file import rv_core_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic [REG_ADDR_W-1:0] rs1_addr_i,
	input  logic [REG_ADDR_W-1:0] rs2_addr_i,
	output logic [XLEN-1:0]       rs1_data_o,
	output logic [XLEN-1:0]       rs2_data_o,
	input  reg_write_t            write_i
);

	// x0 has no storage
	logic [XLEN-1:0] regs [1:31];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_i.wen && (write_i.addr != '0)) begin
			regs[write_i.addr] <= write_i.data;
		end
	end

	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import rv_core_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  fetch_valid_i,
	input  fetch_pkt_t            fetch_pkt_i,
	output logic [REG_ADDR_W-1:0] rs1_addr_o,
	output logic [REG_ADDR_W-1:0] rs2_addr_o,
	input  logic [XLEN-1:0]       rs1_data_i,
	input  logic [XLEN-1:0]       rs2_data_i,
	input  logic                  ex_valid_i,
	input  exec_pkt_t             ex_pkt_i,
	input  reg_write_t            wb_write_i,
	output logic                  dec_valid_o,
	output decode_pkt_t           dec_pkt_o
);

	logic [31:0]           inst;
	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic [REG_ADDR_W-1:0] rd;
	logic [XLEN-1:0]       imm_i;
	logic [XLEN-1:0]       imm_b;
	logic [XLEN-1:0]       imm_u;
	logic [XLEN-1:0]       imm_j;
	logic [XLEN-1:0]       rs1_val;
	logic [XLEN-1:0]       rs2_val;
	logic                  use_imm;
	logic                  use_pc;
	logic                  writes_rd;
	decode_pkt_t           dec_pkt;

	// execute result wins over writeback, writeback over the register file
	function automatic logic [XLEN-1:0] forward(
		input logic [REG_ADDR_W-1:0] addr,
		input logic [XLEN-1:0]       rf_data,
		input logic                  ex_valid,
		input exec_pkt_t             ex_pkt,
		input reg_write_t            wb_write
	);
		logic [XLEN-1:0] value;
		value = rf_data;
		if ((addr != '0) && wb_write.wen && (wb_write.addr == addr)) begin
			value = wb_write.data;
		end
		if ((addr != '0) && ex_valid && ex_pkt.rd_wen && (ex_pkt.rd == addr)) begin
			value = ex_pkt.result;
		end
		return value;
	endfunction

	function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic sub_sra);
		case (f3)
			3'b000: return sub_sra ? ALU_SUB : ALU_ADD;
			3'b001: return ALU_SLL;
			3'b010: return ALU_SLT;
			3'b011: return ALU_SLTU;
			3'b100: return ALU_XOR;
			3'b101: return sub_sra ? ALU_SRA : ALU_SRL;
			3'b110: return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	assign inst = fetch_pkt_i.inst;
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign rd = inst[11:7];
	assign rs1_addr_o = inst[19:15];
	assign rs2_addr_o = inst[24:20];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	assign rs1_val = forward(rs1_addr_o, rs1_data_i, ex_valid_i, ex_pkt_i, wb_write_i);
	assign rs2_val = forward(rs2_addr_o, rs2_data_i, ex_valid_i, ex_pkt_i, wb_write_i);

	always_comb begin
		dec_pkt = '0;
		use_imm = 1'b1;
		use_pc = 1'b0;
		writes_rd = 1'b1;
		dec_pkt.alu_op = ALU_ADD;
		dec_pkt.imm = imm_i;
		case (opcode)
			OPCODE_OP: begin
				use_imm = 1'b0;
				dec_pkt.alu_op = alu_from_funct(funct3, inst[30]);
			end
			// inst[30] picks srai over srli and is ignored for addi
			OPCODE_OP_IMM: begin
				dec_pkt.alu_op = alu_from_funct(funct3, inst[30] && (funct3 == 3'b101));
			end
			OPCODE_LUI: begin
				dec_pkt.imm = imm_u;
				dec_pkt.alu_op = ALU_PASS_B;
			end
			OPCODE_AUIPC: begin
				dec_pkt.imm = imm_u;
				use_pc = 1'b1;
			end
			OPCODE_JAL: begin
				dec_pkt.imm = imm_j;
				use_pc = 1'b1;
			end
			OPCODE_JALR: ;
			OPCODE_BRANCH: begin
				dec_pkt.imm = imm_b;
				use_imm = 1'b0;
				writes_rd = 1'b0;
			end
			default: writes_rd = 1'b0;
		endcase

		// ctrl flags follow the fetch pre-decode so redirects match its wait
		dec_pkt.is_branch = fetch_pkt_i.is_ctrl && (opcode == OPCODE_BRANCH);
		dec_pkt.is_jal = fetch_pkt_i.is_ctrl && (opcode == OPCODE_JAL);
		dec_pkt.is_jalr = fetch_pkt_i.is_ctrl && (opcode == OPCODE_JALR);
		dec_pkt.branch_op = branch_op_e'(funct3);
		dec_pkt.pc = fetch_pkt_i.pc;
		dec_pkt.operand_a = use_pc ? fetch_pkt_i.pc : rs1_val;
		dec_pkt.operand_b = use_imm ? dec_pkt.imm : rs2_val;
		dec_pkt.rs2_val = rs2_val;
		dec_pkt.rd = rd;
		dec_pkt.rd_wen = writes_rd && (rd != '0);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			dec_valid_o <= 1'b0;
		end else begin
			dec_valid_o <= fetch_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_valid_i) begin
			dec_pkt_o <= dec_pkt;
		end
	end

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import rv_core_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        dec_valid_i,
	input  decode_pkt_t dec_pkt_i,
	output logic        ex_valid_o,
	output exec_pkt_t   ex_pkt_o,
	output logic        wb_valid_o,
	output exec_pkt_t   wb_pkt_o
);

	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [4:0]      shamt;
	logic [XLEN-1:0] alu_res;
	logic            cond;
	logic            is_jump;
	logic [XLEN-1:0] link;
	logic [XLEN-1:0] target_base;
	logic [XLEN-1:0] target_sum;

	assign op_a = dec_pkt_i.operand_a;
	assign op_b = dec_pkt_i.operand_b;
	assign shamt = op_b[4:0];

	always_comb begin
		case (dec_pkt_i.alu_op)
			ALU_ADD: alu_res = op_a + op_b;
			ALU_SUB: alu_res = op_a - op_b;
			ALU_SLL: alu_res = op_a << shamt;
			ALU_SLT: alu_res = XLEN'($signed(op_a) < $signed(op_b));
			ALU_SLTU: alu_res = XLEN'(op_a < op_b);
			ALU_XOR: alu_res = op_a ^ op_b;
			ALU_SRL: alu_res = op_a >> shamt;
			ALU_SRA: alu_res = $unsigned($signed(op_a) >>> shamt);
			ALU_OR: alu_res = op_a | op_b;
			ALU_AND: alu_res = op_a & op_b;
			default: alu_res = op_b;
		endcase
	end

	// branch compare works on rs1 against the raw rs2 value
	always_comb begin
		case (dec_pkt_i.branch_op)
			BR_EQ: cond = (op_a == dec_pkt_i.rs2_val);
			BR_NE: cond = (op_a != dec_pkt_i.rs2_val);
			BR_LT: cond = ($signed(op_a) < $signed(dec_pkt_i.rs2_val));
			BR_GE: cond = ($signed(op_a) >= $signed(dec_pkt_i.rs2_val));
			BR_LTU: cond = (op_a < dec_pkt_i.rs2_val);
			BR_GEU: cond = (op_a >= dec_pkt_i.rs2_val);
			default: cond = 1'b0;
		endcase
	end

	assign is_jump = dec_pkt_i.is_jal || dec_pkt_i.is_jalr;
	assign link = dec_pkt_i.pc + XLEN'(4);

	// jalr jumps from rs1, everything else from its own pc
	assign target_base = dec_pkt_i.is_jalr ? op_a : dec_pkt_i.pc;
	assign target_sum = target_base + dec_pkt_i.imm;

	assign ex_valid_o = dec_valid_i;
	assign ex_pkt_o.pc = dec_pkt_i.pc;
	assign ex_pkt_o.result = is_jump ? link : alu_res;
	assign ex_pkt_o.rd = dec_pkt_i.rd;
	assign ex_pkt_o.rd_wen = dec_pkt_i.rd_wen;
	assign ex_pkt_o.is_ctrl = dec_pkt_i.is_branch || is_jump;
	assign ex_pkt_o.taken = is_jump || (dec_pkt_i.is_branch && cond);
	assign ex_pkt_o.jump_target = dec_pkt_i.is_jalr ? {target_sum[XLEN-1:1], 1'b0} : target_sum;

	always_ff @(posedge clock) begin
		if (reset) begin
			wb_valid_o <= 1'b0;
		end else begin
			wb_valid_o <= dec_valid_i;
		end
	end

	always_ff @(posedge clock) begin
		if (dec_valid_i) begin
			wb_pkt_o <= ex_pkt_o;
		end
	end

endmodule

/* logic/writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage import rv_core_pkg::*; (
	input  logic            wb_valid_i,
	input  exec_pkt_t       wb_pkt_i,
	output reg_write_t      write_o,
	output logic            redirect_valid_o,
	output logic [XLEN-1:0] redirect_pc_o,
	output logic            commit_valid_o,
	output commit_t         commit_o
);

	logic [XLEN-1:0] next_pc;

	assign write_o.wen = wb_valid_i && wb_pkt_i.rd_wen;
	assign write_o.addr = wb_pkt_i.rd;
	assign write_o.data = wb_pkt_i.result;

	// not-taken branches fall through
	assign next_pc = wb_pkt_i.pc + XLEN'(4);
	assign redirect_valid_o = wb_valid_i && wb_pkt_i.is_ctrl;
	assign redirect_pc_o = wb_pkt_i.taken ? wb_pkt_i.jump_target : next_pc;

	assign commit_valid_o = wb_valid_i;
	assign commit_o.pc = wb_pkt_i.pc;
	assign commit_o.rd = wb_pkt_i.rd;
	assign commit_o.rd_wen = wb_pkt_i.rd_wen;
	assign commit_o.data = wb_pkt_i.result;

endmodule

/* logic/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top import rv_core_pkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
	input  logic            clock,
	input  logic            reset,
	output logic            fetch_req_o,
	output logic [XLEN-1:0] fetch_addr_o,
	input  logic            fetch_valid_i,
	input  logic [31:0]     fetch_inst_i,
	output logic            commit_valid_o,
	output commit_t         commit_o
);

	logic                  fetch_valid;
	fetch_pkt_t            fetch_pkt;
	logic                  dec_valid;
	decode_pkt_t           dec_pkt;
	logic                  ex_valid;
	exec_pkt_t             ex_pkt;
	logic                  wb_valid;
	exec_pkt_t             wb_pkt;
	logic [REG_ADDR_W-1:0] rs1_addr;
	logic [REG_ADDR_W-1:0] rs2_addr;
	logic [XLEN-1:0]       rs1_data;
	logic [XLEN-1:0]       rs2_data;
	reg_write_t            reg_write;
	logic                  redirect_valid;
	logic [XLEN-1:0]       redirect_pc;

	fetch_stage #(
		.RESET_PC(RESET_PC)
	) u_fetch (
		.clock           (clock),
		.reset           (reset),
		.fetch_req_o     (fetch_req_o),
		.fetch_addr_o    (fetch_addr_o),
		.fetch_valid_i   (fetch_valid_i),
		.fetch_inst_i    (fetch_inst_i),
		.redirect_valid_i(redirect_valid),
		.redirect_pc_i   (redirect_pc),
		.fetch_valid_o   (fetch_valid),
		.fetch_pkt_o     (fetch_pkt)
	);

	decode_stage u_decode (
		.clock        (clock),
		.reset        (reset),
		.fetch_valid_i(fetch_valid),
		.fetch_pkt_i  (fetch_pkt),
		.rs1_addr_o   (rs1_addr),
		.rs2_addr_o   (rs2_addr),
		.rs1_data_i   (rs1_data),
		.rs2_data_i   (rs2_data),
		.ex_valid_i   (ex_valid),
		.ex_pkt_i     (ex_pkt),
		.wb_write_i   (reg_write),
		.dec_valid_o  (dec_valid),
		.dec_pkt_o    (dec_pkt)
	);

	register_file u_regfile (
		.clock     (clock),
		.reset     (reset),
		.rs1_addr_i(rs1_addr),
		.rs2_addr_i(rs2_addr),
		.rs1_data_o(rs1_data),
		.rs2_data_o(rs2_data),
		.write_i   (reg_write)
	);

	execute_stage u_execute (
		.clock      (clock),
		.reset      (reset),
		.dec_valid_i(dec_valid),
		.dec_pkt_i  (dec_pkt),
		.ex_valid_o (ex_valid),
		.ex_pkt_o   (ex_pkt),
		.wb_valid_o (wb_valid),
		.wb_pkt_o   (wb_pkt)
	);

	writeback_stage u_writeback (
		.wb_valid_i      (wb_valid),
		.wb_pkt_i        (wb_pkt),
		.write_o         (reg_write),
		.redirect_valid_o(redirect_valid),
		.redirect_pc_o   (redirect_pc),
		.commit_valid_o  (commit_valid_o),
		.commit_o        (commit_o)
	);

endmodule

/* dv/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb import rv_core_pkg::*; ();

	localparam logic [XLEN-1:0] BASE = 32'h8000_0000;
	// jal x0, 0
	localparam logic [31:0] SELF_JUMP = 32'h0000_006f;

	logic            clock = 1'b0;
	logic            reset = 1'b1;
	logic            fetch_req;
	logic [XLEN-1:0] fetch_addr;
	logic            fetch_valid = 1'b0;
	logic [31:0]     fetch_inst = '0;
	logic            commit_valid;
	commit_t         commit;

	logic [31:0]     imem [256];
	int              prog_len = 0;
	logic [31:0]     model_regs [32];
	logic [XLEN-1:0] model_pc = BASE;
	string           test_name = "none";
	int              cycle = 0;
	int              commits = 0;
	int              expect_req = 0;
	logic [XLEN-1:0] expect_addr = '0;
	int              fetch_cycles [$];
	logic            mem_busy = 1'b0;
	int              mem_wait = 0;
	logic [XLEN-1:0] mem_addr = '0;
	logic [4:0]      br_rs1 [3] = '{5'd1, 5'd3, 5'd2};
	logic [4:0]      br_rs2 [3] = '{5'd3, 5'd2, 5'd2};

	rv_core_top #(
		.RESET_PC(BASE)
	) DUT (
		.clock         (clock),
		.reset         (reset),
		.fetch_req_o   (fetch_req),
		.fetch_addr_o  (fetch_addr),
		.fetch_valid_i (fetch_valid),
		.fetch_inst_i  (fetch_inst),
		.commit_valid_o(commit_valid),
		.commit_o      (commit)
	);

	initial begin
		forever #2 clock = ~clock;
	end

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPCODE_OP};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPCODE_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPCODE_JAL};
	endfunction

	function automatic logic is_ctrl_op(input logic [6:0] op);
		return (op == OPCODE_JAL) || (op == OPCODE_JALR) || (op == OPCODE_BRANCH);
	endfunction

	// anything past the loaded program is a self-jump
	function automatic logic [31:0] imem_read(input logic [XLEN-1:0] addr);
		logic [XLEN-1:0] offset;
		offset = addr - BASE;
		if ((offset[1:0] == 2'b00) && ((offset >> 2) < prog_len)) begin
			return imem[offset >> 2];
		end
		return SELF_JUMP;
	endfunction

	function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'b0, $signed(a) < $signed(b)};
			3'b011: return {31'b0, a < b};
			3'b100: return a ^ b;
			3'b101: begin
				if (alt) begin
					return $signed(a) >>> b[4:0];
				end
				return a >> b[4:0];
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	// architectural step returning the commit record the core should show
	function automatic commit_t model_step(input logic [31:0] inst);
		logic [2:0]  f3;
		logic [4:0]  rd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic [31:0] next_pc;
		logic        taken;
		commit_t     c;
		f3 = inst[14:12];
		rd = inst[11:7];
		a = model_regs[inst[19:15]];
		b = model_regs[inst[24:20]];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
		imm_u = {inst[31:12], 12'b0};
		imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
		c.pc = model_pc;
		c.rd = rd;
		c.rd_wen = 1'b1;
		c.data = '0;
		next_pc = model_pc + 32'd4;
		taken = 1'b0;
		case (inst[6:0])
			OPCODE_OP: c.data = alu_result(f3, inst[30], a, b);
			OPCODE_OP_IMM: c.data = alu_result(f3, inst[30] && (f3 == 3'b101), a, imm_i);
			OPCODE_LUI: c.data = imm_u;
			OPCODE_AUIPC: c.data = model_pc + imm_u;
			OPCODE_JAL: begin
				c.data = model_pc + 32'd4;
				next_pc = model_pc + imm_j;
			end
			OPCODE_JALR: begin
				c.data = model_pc + 32'd4;
				next_pc = (a + imm_i) & ~32'h1;
			end
			OPCODE_BRANCH: begin
				c.rd_wen = 1'b0;
				case (f3)
					3'b000: taken = (a == b);
					3'b001: taken = (a != b);
					3'b100: taken = ($signed(a) < $signed(b));
					3'b101: taken = ($signed(a) >= $signed(b));
					3'b110: taken = (a < b);
					3'b111: taken = (a >= b);
					default: taken = 1'b0;
				endcase
				if (taken) begin
					next_pc = model_pc + imm_b;
				end
			end
			default: c.rd_wen = 1'b0;
		endcase
		if (rd == 5'd0) begin
			c.rd_wen = 1'b0;
		end
		if (c.rd_wen) begin
			model_regs[rd] = c.data;
		end
		model_pc = next_pc;
		return c;
	endfunction

	task automatic compare_values(input string what, input logic [69:0] expected,
		input logic [69:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s %s: expected %h, actual %h",
				test_name, what, expected, actual);
			$display("Test failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic append_inst(input logic [31:0] inst);
		imem[prog_len] = inst;
		prog_len++;
	endtask

	// small register pool so results feed each other
	function automatic logic [31:0] random_alu_inst();
		logic [2:0]  f3;
		logic        alt;
		logic [11:0] imm;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		f3 = 3'($urandom_range(0, 7));
		alt = ((f3 == 3'b000) || (f3 == 3'b101)) && ($urandom_range(0, 1) == 1);
		rd = 5'($urandom_range(1, 4));
		rs1 = 5'($urandom_range(0, 4));
		rs2 = 5'($urandom_range(0, 4));
		imm = 12'($urandom);
		if ($urandom_range(0, 1) == 1) begin
			return enc_r({1'b0, alt, 5'b0}, rs2, rs1, f3, rd);
		end
		if ((f3 == 3'b001) || (f3 == 3'b101)) begin
			imm = {1'b0, alt, 5'b0, imm[4:0]};
		end
		return enc_i(imm, rs1, f3, rd, OPCODE_OP_IMM);
	endfunction

	// only forward branches and jumps
	function automatic logic [31:0] random_mixed_inst();
		int         pick;
		logic [2:0] f3;
		logic [4:0] rs1;
		logic [4:0] rs2;
		pick = $urandom_range(0, 9);
		f3 = 3'($urandom_range(0, 5));
		if (f3 >= 3'd2) begin
			f3 = f3 + 3'd2;
		end
		rs1 = 5'($urandom_range(0, 4));
		rs2 = 5'($urandom_range(0, 4));
		if (pick == 0) begin
			return enc_u(20'($urandom), 5'($urandom_range(1, 4)), OPCODE_LUI);
		end else if (pick == 1) begin
			return enc_u(20'($urandom), 5'($urandom_range(1, 4)), OPCODE_AUIPC);
		end else if (pick == 2) begin
			return enc_b(13'(4 * $urandom_range(1, 4)), rs2, rs1, f3);
		end else if (pick == 3) begin
			return enc_j(21'(4 * $urandom_range(1, 3)), rs1);
		end
		return random_alu_inst();
	endfunction

	// instruction memory answering each request after 1 to 4 cycles
	always @(posedge clock) begin
		fetch_valid <= 1'b0;
		if (reset) begin
			mem_busy = 1'b0;
		end else begin
			if (fetch_req) begin
				mem_busy = 1'b1;
				mem_addr = fetch_addr;
				mem_wait = $urandom_range(1, 4);
			end
			if (mem_busy) begin
				if (mem_wait == 1) begin
					fetch_valid <= 1'b1;
					fetch_inst <= imem_read(mem_addr);
					mem_busy = 1'b0;
				end else begin
					mem_wait = mem_wait - 1;
				end
			end
		end
	end

	always @(posedge clock) begin
		logic [31:0] inst;
		commit_t     expected;
		commit_t     actual;
		cycle = cycle + 1;
		if (reset) begin
			commits = 0;
			fetch_cycles.delete();
			expect_req = cycle + 1;
			expect_addr = BASE;
		end else begin
			compare_values("fetch_req", cycle == expect_req, fetch_req);
			if (fetch_req) begin
				compare_values("fetch_addr", expect_addr, fetch_addr);
			end
			if (fetch_valid) begin
				fetch_cycles.push_back(cycle);
				if (!is_ctrl_op(fetch_inst[6:0])) begin
					expect_req = cycle + 1;
					expect_addr = expect_addr + 32'd4;
				end
			end
			if (commit_valid && (fetch_cycles.size() == 0)) begin
				$display("commit in %s without any fetched instruction", test_name);
				$display("Test failed");
				$fatal(1, "unexpected commit");
			end else if (commit_valid) begin
				compare_values("latency", 3, cycle - fetch_cycles.pop_front());
				inst = imem_read(model_pc);
				expected = model_step(inst);
				actual = commit;
				// data is undefined when nothing is written
				if (!expected.rd_wen) begin
					expected.data = '0;
					actual.data = '0;
				end
				compare_values("commit", expected, actual);
				if (is_ctrl_op(inst[6:0])) begin
					expect_req = cycle + 1;
					expect_addr = model_pc;
				end
				commits++;
			end
		end
	end

	task automatic run_program(input string name, input int count);
		int waited;
		test_name = name;
		model_pc = BASE;
		foreach (model_regs[i]) begin
			model_regs[i] = '0;
		end
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		waited = 0;
		while (commits < count) begin
			@(negedge clock);
			waited++;
			if (waited > count * 10) begin
				$display("timeout in %s after %0d of %0d commits", name, commits, count);
				$display("Test failed");
				$fatal(1, "run did not finish in time");
			end
		end
		@(posedge clock);
		reset <= 1'b1;
		@(posedge clock);
	endtask

	initial begin
		void'($urandom(32'h31e1_374d));
		repeat (40) append_inst(random_alu_inst());
		run_program("alu_chain", prog_len);

		prog_len = 0;
		append_inst(enc_u(20'habcde, 5'd1, OPCODE_LUI));
		append_inst(enc_u(20'h12345, 5'd2, OPCODE_AUIPC));
		append_inst(enc_u(20'hfffff, 5'd3, OPCODE_AUIPC));
		append_inst(enc_i(12'hfff, 5'd1, 3'b000, 5'd4, OPCODE_OP_IMM));
		append_inst(enc_u(20'h00001, 5'd0, OPCODE_LUI));
		run_program("upper_imm", prog_len);

		// x1 = 0x80000000, x2 = 1, x3 = -1
		prog_len = 0;
		append_inst(enc_u(20'h80000, 5'd1, OPCODE_LUI));
		append_inst(enc_i(12'd1, 5'd0, 3'b000, 5'd2, OPCODE_OP_IMM));
		append_inst(enc_i(12'hfff, 5'd0, 3'b000, 5'd3, OPCODE_OP_IMM));
		for (int p = 0; p < 3; p++) begin
			for (int k = 0; k < 6; k++) begin
				append_inst(enc_b(13'd8, br_rs2[p], br_rs1[p], 3'((k < 2) ? k : k + 2)));
				append_inst(enc_i(12'd1, 5'd5, 3'b000, 5'd5, OPCODE_OP_IMM));
			end
		end
		run_program("branches", prog_len);

		prog_len = 0;
		append_inst(enc_i(12'd7, 5'd0, 3'b000, 5'd1, OPCODE_OP_IMM));
		append_inst(enc_j(21'd8, 5'd5));
		append_inst(enc_i(12'd100, 5'd1, 3'b000, 5'd1, OPCODE_OP_IMM));
		append_inst(enc_u(20'h0, 5'd7, OPCODE_AUIPC));
		// odd target sum that jalr rounds down to slot six
		append_inst(enc_i(12'd13, 5'd7, 3'b000, 5'd6, OPCODE_JALR));
		append_inst(enc_i(12'd200, 5'd1, 3'b000, 5'd1, OPCODE_OP_IMM));
		append_inst(enc_r(7'b0, 5'd6, 5'd5, 3'b000, 5'd2));
		append_inst(enc_i(12'd29, 5'd7, 3'b000, 5'd7, OPCODE_JALR));
		append_inst(enc_i(12'd1, 5'd1, 3'b000, 5'd1, OPCODE_OP_IMM));
		append_inst(enc_i(12'd2, 5'd1, 3'b000, 5'd1, OPCODE_OP_IMM));
		append_inst(enc_i(12'd0, 5'd7, 3'b000, 5'd9, OPCODE_OP_IMM));
		run_program("jumps", prog_len);

		prog_len = 0;
		append_inst(enc_i(12'd5, 5'd0, 3'b000, 5'd0, OPCODE_OP_IMM));
		append_inst(enc_r(7'b0, 5'd0, 5'd0, 3'b000, 5'd1));
		append_inst(enc_u(20'h00001, 5'd1, OPCODE_LUI));
		append_inst(32'h0000_2083);
		append_inst(enc_i(12'd0, 5'd1, 3'b000, 5'd2, OPCODE_OP_IMM));
		append_inst(32'h0000_0073);
		append_inst(enc_i(12'd0, 5'd0, 3'b110, 5'd3, OPCODE_OP_IMM));
		run_program("x0_and_unsupported", prog_len);

		prog_len = 0;
		repeat (64) append_inst(random_mixed_inst());
		run_program("random_program", prog_len);

		$display("Test passed");
		$finish;
	end

endmodule

/* filelist.f */
logic/rv_core_pkg.sv
logic/fetch_stage.sv
logic/register_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/rv_core_top.sv
dv/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - logic/rv_core_pkg.sv
  - logic/fetch_stage.sv
  - logic/register_file.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/writeback_stage.sv
  - logic/rv_core_top.sv
  - target: test
    files:
      - dv/rv_core_tb.sv
